// ==== rtl/vec_pkg.sv ====
`default_nettype none

package vec_pkg;

	//////////////////////////////
	// Field widths
	//////////////////////////////
	localparam int REG_IDX_W = 5;	// Vector and scalar register index
	localparam int FUNCT_W   = 4;	// Vector operation code
	localparam int XLEN      = 32;	// Scalar data path
	localparam int ID_W      = 3;	// Issue id, sized for an 8-deep record

	// Major opcodes of the vector extension, anything else is scalar
	typedef enum logic [6:0] {
		OP_VEC_LOAD  = 7'b0000111,
		OP_VEC_STORE = 7'b0100111,
		OP_VEC_ARITH = 7'b1010111
	} vec_opcode_e;

	// Second ALU operand
	typedef enum logic [1:0] {
		SRC_VS  = 2'b00,	// Vector register
		SRC_RS  = 2'b01,	// Scalar register value
		SRC_IMM = 2'b11		// uimm5
	} alu_src_e;

	// Load/store addressing
	typedef enum logic [1:0] {
		UNIT    = 2'b00,
		STRIDED = 2'b01,
		INDEXED = 2'b11
	} lsu_mode_e;

	//////////////////////////////
	// Decoded vector instruction
	//////////////////////////////
	typedef struct packed {
		logic [REG_IDX_W-1:0] vs1;
		logic [REG_IDX_W-1:0] vs2;
		logic [REG_IDX_W-1:0] vd;
		logic [REG_IDX_W-1:0] rs1;	// Scalar source selects
		logic [REG_IDX_W-1:0] rs2;
		logic [REG_IDX_W-1:0] uimm5;
		logic [FUNCT_W-1:0]   funct;
		logic [1:0]           permute;	// Slide amount 0..3
		logic                 mask_en;
		alu_src_e             alu_src;
		logic                 dmr;	// Data memory read
		logic                 dmw;	// Data memory write
		logic                 reg_we;	// Vector register write
		logic                 mem_reg;	// Write data from memory, not ALU
		lsu_mode_e            mode_lsu;
	} vec_inst_t;

	// One issue slot towards the execution unit
	typedef struct packed {
		logic [ID_W-1:0] id;
		vec_inst_t       inst;
		logic [XLEN-1:0] rs1_val;	// Scalar operands read at issue
		logic [XLEN-1:0] rs2_val;
	} vec_issue_t;

endpackage

`default_nettype wire

// ==== rtl/vec_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_decode_stage (
	input  wire logic                     reset,	// Clock
	input  wire logic                     clk,	// Async reset, active high
	input  wire logic [vec_pkg::XLEN-1:0] instr,
	input  wire logic                     instr_strobe,
	output vec_pkg::vec_inst_t            dec_item,
	output logic                          dec_vec,	// One cycle, vector word decoded
	output logic                          dec_scalar	// One cycle, scalar word seen
);

	import vec_pkg::*;

	vec_opcode_e opcode;
	logic        is_vec;
	vec_inst_t   dec_next;

	assign opcode = vec_opcode_e'(instr[6:0]);
	assign is_vec = (opcode == OP_VEC_LOAD) || (opcode == OP_VEC_STORE) ||
		(opcode == OP_VEC_ARITH);

	//////////////////////////////
	// Field extraction
	//////////////////////////////
	always_comb
	begin
		dec_next          = '0;
		dec_next.vd       = instr[11:7];
		dec_next.vs1      = instr[19:15];
		dec_next.rs1      = instr[19:15];	// Same slot, meaning depends on funct3
		dec_next.uimm5    = instr[19:15];
		dec_next.vs2      = instr[24:20];
		dec_next.rs2      = instr[24:20];
		dec_next.funct    = instr[31:28];
		dec_next.permute  = instr[27:26];
		dec_next.mode_lsu = lsu_mode_e'(instr[27:26]);	// Shares bits with permute
		dec_next.mask_en  = ~instr[25];	// vm=0 means masked
		// Operand source from funct3
		case (instr[14:12])
			3'b100:  dec_next.alu_src = SRC_RS;
			3'b011:  dec_next.alu_src = SRC_IMM;
			default: dec_next.alu_src = SRC_VS;	// 000 and unused codes
		endcase
		// Control bits by major opcode
		case (opcode)
			OP_VEC_LOAD:
			begin
				dec_next.dmr     = 1'b1;
				dec_next.reg_we  = 1'b1;
				dec_next.mem_reg = 1'b1;
			end
			OP_VEC_STORE: dec_next.dmw    = 1'b1;
			OP_VEC_ARITH: dec_next.reg_we = 1'b1;
			default: ;	// Scalar word, controls stay zero
		endcase
	end

	// Decoded payload, only loaded on a strobe
	always_ff @(posedge reset)
	begin
		if (instr_strobe)
			dec_item <= dec_next;
	end

	// Class pulses
	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
		begin
			dec_vec    <= 1'b0;
			dec_scalar <= 1'b0;
		end
		else
		begin
			dec_vec    <= instr_strobe & is_vec;
			dec_scalar <= instr_strobe & ~is_vec;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/inst_record.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_record #(
	parameter int DEPTH = 8
) (
	input  wire logic                       reset,	// Clock
	input  wire logic                       clk,	// Async reset, active high
	input  wire vec_pkg::vec_inst_t         dec_item,
	input  wire logic                       dec_vec,
	input  wire logic                       dec_scalar,
	input  wire logic [$clog2(DEPTH)-1:0]   rd_idx,	// From dispatch counter
	input  wire logic                       convoy_release,	// Empty and collect again
	output vec_pkg::vec_inst_t              rd_item,
	output logic                            convoy_ready,	// One cycle after close
	output logic [$clog2(DEPTH+1)-1:0]      convoy_count
);

	import vec_pkg::*;

	localparam int IDX_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH+1);	// Must hold DEPTH itself

	typedef enum logic {
		REC_COLLECT,
		REC_HOLD
	} rec_state_e;

	rec_state_e       state;
	vec_inst_t        mem [DEPTH];	// Convoy storage
	logic [CNT_W-1:0] wr_ptr;	// Next free slot, also item count
	logic             wr_en;
	logic             close_full;
	logic             close_scalar;

	//////////////////////////////
	// Close conditions
	//////////////////////////////
	assign wr_en        = (state == REC_COLLECT) && dec_vec;
	assign close_full   = wr_en && (wr_ptr == CNT_W'(DEPTH - 1));	// DEPTH-th write
	assign close_scalar = (state == REC_COLLECT) && dec_scalar &&
		(wr_ptr != '0);	// Scalar on empty record is ignored

	// Entry write, consecutive slots from 0
	always_ff @(posedge reset)
	begin
		if (wr_en)
			mem[wr_ptr[IDX_W-1:0]] <= dec_item;
	end

	//////////////////////////////
	// Record control
	//////////////////////////////
	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
		begin
			state        <= REC_COLLECT;
			wr_ptr       <= '0;
			convoy_ready <= 1'b0;
		end
		else
		begin
			convoy_ready <= 1'b0;	// Pulse by default
			case (state)
				REC_COLLECT:
				begin
					if (wr_en)
						wr_ptr <= wr_ptr + 1'b1;
					if (close_full || close_scalar)
					begin
						state        <= REC_HOLD;	// Freeze contents for dispatch
						convoy_ready <= 1'b1;
					end
				end
				REC_HOLD:
				begin
					// Decode traffic dropped here until the convoy ends
					if (convoy_release)
					begin
						wr_ptr <= '0;
						state  <= REC_COLLECT;
					end
				end
				default: state <= REC_COLLECT;
			endcase
		end
	end

	// Read side for dispatch
	assign rd_item      = mem[rd_idx];
	assign convoy_count = wr_ptr;	// Stable while holding

endmodule

`default_nettype wire

// ==== rtl/dispatch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module dispatch_stage #(
	parameter int DEPTH = 8
) (
	input  wire logic                          reset,	// Clock
	input  wire logic                          clk,	// Async reset, active high
	input  wire logic                          convoy_ready,
	input  wire logic [$clog2(DEPTH+1)-1:0]    convoy_count,
	input  wire vec_pkg::vec_inst_t            rd_item,
	input  wire logic [vec_pkg::XLEN-1:0]      rs1_data,	// Scalar RF read data
	input  wire logic [vec_pkg::XLEN-1:0]      rs2_data,
	input  wire logic                          exe_stall,
	input  wire logic                          exe_done,
	output logic [$clog2(DEPTH)-1:0]           rd_idx,
	output logic [vec_pkg::REG_IDX_W-1:0]      rs1_sel,
	output logic [vec_pkg::REG_IDX_W-1:0]      rs2_sel,
	output vec_pkg::vec_issue_t                issue,
	output logic                               issue_start,
	output logic                               issue_clear,
	output logic                               convoy_busy,
	output logic                               convoy_release
);

	import vec_pkg::*;

	localparam int IDX_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH+1);

	typedef enum logic [1:0] {
		DSP_IDLE,
		DSP_ISSUE,
		DSP_DRAIN
	} dsp_state_e;

	dsp_state_e       state;
	logic [IDX_W-1:0] disp_cnt;	// Next item to issue
	logic             issue_fire;
	logic             last_item;

	assign issue_fire = (state == DSP_ISSUE) && !exe_stall;	// Stall only holds, never drops
	assign last_item  = CNT_W'(disp_cnt) == (convoy_count - CNT_W'(1));

	// Record lookup and scalar RF selects
	assign rd_idx  = disp_cnt;
	assign rs1_sel = rd_item.rs1;
	assign rs2_sel = rd_item.rs2;

	assign convoy_busy = (state != DSP_IDLE);

	// Issue payload, operands sampled on the issuing edge
	always_ff @(posedge reset)
	begin
		if (issue_fire)
		begin
			issue.id      <= ID_W'(disp_cnt);
			issue.inst    <= rd_item;
			issue.rs1_val <= rs1_data;
			issue.rs2_val <= rs2_data;
		end
	end

	//////////////////////////////
	// Dispatch FSM
	//////////////////////////////
	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
		begin
			state          <= DSP_IDLE;
			disp_cnt       <= '0;
			issue_start    <= 1'b0;
			issue_clear    <= 1'b1;	// Execution unit held clear out of reset
			convoy_release <= 1'b0;
		end
		else
		begin
			issue_start    <= 1'b0;
			convoy_release <= 1'b0;
			if (convoy_release)
				issue_clear <= 1'b0;	// End of the convoy-end clear pulse
			case (state)
				DSP_IDLE:
				begin
					disp_cnt <= '0;
					if (convoy_ready)
						state <= DSP_ISSUE;	// First issue next cycle
				end
				DSP_ISSUE:
				begin
					if (issue_fire)
					begin
						issue_start <= 1'b1;
						issue_clear <= 1'b0;
						if (last_item)
							state <= DSP_DRAIN;
						else
							disp_cnt <= disp_cnt + 1'b1;
					end
				end
				DSP_DRAIN:
				begin
					// Wait for the execution unit to finish
					if (exe_done)
					begin
						issue_clear    <= 1'b1;
						convoy_release <= 1'b1;
						disp_cnt       <= '0;
						state          <= DSP_IDLE;
					end
				end
				default: state <= DSP_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/vector_issue_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vector_issue_top #(
	parameter int DEPTH = 8	// Convoy record depth
) (
	input  wire logic                         reset,	// Clock
	input  wire logic                         clk,	// Async reset, active high
	input  wire logic [vec_pkg::XLEN-1:0]     instr,
	input  wire logic                         instr_strobe,
	input  wire logic [vec_pkg::XLEN-1:0]     rs1_data,
	input  wire logic [vec_pkg::XLEN-1:0]     rs2_data,
	input  wire logic                         exe_stall,
	input  wire logic                         exe_done,
	output vec_pkg::vec_issue_t               issue,
	output logic                              issue_start,
	output logic                              issue_clear,
	output logic [vec_pkg::REG_IDX_W-1:0]     rs1_sel,
	output logic [vec_pkg::REG_IDX_W-1:0]     rs2_sel,
	output logic                              convoy_busy
);

	import vec_pkg::*;

	//////////////////////////////
	// Stage interconnect
	//////////////////////////////
	vec_inst_t                    dec_item;
	logic                         dec_vec;
	logic                         dec_scalar;
	vec_inst_t                    rd_item;
	logic [$clog2(DEPTH)-1:0]     rd_idx;
	logic                         convoy_ready;
	logic [$clog2(DEPTH+1)-1:0]   convoy_count;
	logic                         convoy_release;

	// Strobed word to decoded item
	vec_decode_stage decode_inst (
		.reset        (reset),
		.clk          (clk),
		.instr        (instr),
		.instr_strobe (instr_strobe),
		.dec_item     (dec_item),
		.dec_vec      (dec_vec),
		.dec_scalar   (dec_scalar)
	);

	// Convoy capture
	inst_record #(
		.DEPTH (DEPTH)
	) record_inst (
		.reset          (reset),
		.clk            (clk),
		.dec_item       (dec_item),
		.dec_vec        (dec_vec),
		.dec_scalar     (dec_scalar),
		.rd_idx         (rd_idx),
		.convoy_release (convoy_release),
		.rd_item        (rd_item),
		.convoy_ready   (convoy_ready),
		.convoy_count   (convoy_count)
	);

	// In-order issue to the execution unit
	dispatch_stage #(
		.DEPTH (DEPTH)
	) dispatch_inst (
		.reset          (reset),
		.clk            (clk),
		.convoy_ready   (convoy_ready),
		.convoy_count   (convoy_count),
		.rd_item        (rd_item),
		.rs1_data       (rs1_data),
		.rs2_data       (rs2_data),
		.exe_stall      (exe_stall),
		.exe_done       (exe_done),
		.rd_idx         (rd_idx),
		.rs1_sel        (rs1_sel),
		.rs2_sel        (rs2_sel),
		.issue          (issue),
		.issue_start    (issue_start),
		.issue_clear    (issue_clear),
		.convoy_busy    (convoy_busy),
		.convoy_release (convoy_release)
	);

endmodule

`default_nettype wire

// ==== tests/tb_vector_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vector_issue;

	import vec_pkg::*;

	localparam int DRIVE_DLY  = 1;	// Input drive offset after the rising edge
	localparam int WAIT_LIMIT = 200;	// Cycles per wait loop

	logic              reset;	// Clock
	logic              clk;	// Async active-high reset
	logic [XLEN-1:0]   instr;
	logic              instr_strobe;
	logic [XLEN-1:0]   rs1_data;
	logic [XLEN-1:0]   rs2_data;
	logic              exe_stall;
	logic              exe_done;
	vec_issue_t        issue;
	logic              issue_start;
	logic              issue_clear;
	logic [REG_IDX_W-1:0] rs1_sel;
	logic [REG_IDX_W-1:0] rs2_sel;
	logic              convoy_busy;

	logic [XLEN-1:0] regfile [32];	// Scalar RF model
	logic [31:0]     lfsr_state;
	logic [31:0]     pending_q [$];	// Vector words strobed since the last convoy
	vec_issue_t      got_q [$];	// Items seen on the issue port
	int              checks;
	int              errors;

	vector_issue_top #(
		.DEPTH (8)
	) vector_issue_top_inst (
		.reset        (reset),
		.clk          (clk),
		.instr        (instr),
		.instr_strobe (instr_strobe),
		.rs1_data     (rs1_data),
		.rs2_data     (rs2_data),
		.exe_stall    (exe_stall),
		.exe_done     (exe_done),
		.issue        (issue),
		.issue_start  (issue_start),
		.issue_clear  (issue_clear),
		.rs1_sel      (rs1_sel),
		.rs2_sel      (rs2_sel),
		.convoy_busy  (convoy_busy)
	);

	always #4 reset = ~reset;	// 8 ns period

	assign rs1_data = regfile[rs1_sel];	// RF read ports follow the selects
	assign rs2_data = regfile[rs2_sel];

	// Issue monitor on the falling edge
	always @(negedge reset)
	begin
		if (issue_start)
			got_q.push_back(issue);
	end

	//////////////////////////////
	// Reference models
	//////////////////////////////
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];	// Taps 32, 22, 2, 1
		return {s[30:0], fb};
	endfunction

	function automatic logic is_vector(input logic [31:0] w);
		return (w[6:0] == 7'b0000111) || (w[6:0] == 7'b0100111) ||
			(w[6:0] == 7'b1010111);
	endfunction

	function automatic vec_inst_t ref_decode(input logic [31:0] w);
		vec_inst_t d;
		d          = '0;
		d.vd       = w[11:7];
		d.vs1      = w[19:15];
		d.rs1      = w[19:15];
		d.uimm5    = w[19:15];
		d.vs2      = w[24:20];
		d.rs2      = w[24:20];
		d.funct    = w[31:28];
		d.permute  = w[27:26];
		d.mode_lsu = lsu_mode_e'(w[27:26]);
		d.mask_en  = !w[25];	// Masked when vm is clear
		if (w[14:12] == 3'b100)
			d.alu_src = SRC_RS;
		else if (w[14:12] == 3'b011)
			d.alu_src = SRC_IMM;
		else
			d.alu_src = SRC_VS;
		if (w[6:0] == 7'b0000111)
		begin
			d.dmr     = 1'b1;	// Load
			d.reg_we  = 1'b1;
			d.mem_reg = 1'b1;
		end
		else if (w[6:0] == 7'b0100111)
			d.dmw = 1'b1;	// Store
		else if (w[6:0] == 7'b1010111)
			d.reg_we = 1'b1;	// Arith
		return d;
	endfunction

	task automatic check_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("ERR %s expected %0h actual %0h", name, expected, actual);
		end
	endtask

	task automatic next_cycle();
		@(posedge reset);
		#DRIVE_DLY;
	endtask

	// One-cycle strobe of an instruction word
	task automatic strobe_word(input logic [31:0] w);
		next_cycle();
		instr        = w;
		instr_strobe = 1'b1;
		next_cycle();
		instr_strobe = 1'b0;
	endtask

	//////////////////////////////
	// Convoy dispatch and compare
	//////////////////////////////
	task automatic run_convoy(input int count, input logic [7:0] pattern, input int idx);
		int        cyc;
		int        bit_i;
		vec_inst_t exp_inst;
		if (count == 0)
		begin
			repeat (16) next_cycle();	// Idle window with scalar words only
			check_value($sformatf("convoy%0d idle issues", idx), 0, got_q.size());
			check_value($sformatf("convoy%0d idle busy", idx), 0, convoy_busy);
		end
		else
		begin
			cyc = 0;
			while (!convoy_busy && cyc < WAIT_LIMIT)
			begin
				next_cycle();
				cyc++;
			end
			if (!convoy_busy)
			begin
				errors++;
				$display("Timeout: convoy %0d never started dispatch", idx);
			end
			cyc   = 0;
			bit_i = 0;
			while (got_q.size() < count && cyc < WAIT_LIMIT)
			begin
				exe_stall = pattern[7 - (bit_i % 8)];	// Leftmost bit first
				bit_i++;
				next_cycle();
				cyc++;
			end
			exe_stall = 1'b0;
			if (got_q.size() < count)
			begin
				errors++;
				$display("Timeout: convoy %0d issued only %0d items", idx,
					got_q.size());
			end
			check_value($sformatf("convoy%0d clear while issuing", idx), 0, issue_clear);
			next_cycle();
			exe_done = 1'b1;	// Execution unit finished
			next_cycle();
			exe_done = 1'b0;
			cyc = 0;
			while (!issue_clear && cyc < WAIT_LIMIT)
			begin
				next_cycle();
				cyc++;
			end
			if (!issue_clear)
			begin
				errors++;
				$display("Timeout: convoy %0d end was never signalled", idx);
			end
			check_value($sformatf("convoy%0d busy at end", idx), 0, convoy_busy);
			next_cycle();
			check_value($sformatf("convoy%0d clear pulse", idx), 0, issue_clear);
			check_value($sformatf("convoy%0d issue count", idx), count, got_q.size());
			for (int i = 0; i < got_q.size() && i < count && i < pending_q.size(); i++)
			begin
				exp_inst = ref_decode(pending_q[i]);
				check_value($sformatf("convoy%0d item%0d id", idx, i), i, got_q[i].id);
				check_value($sformatf("convoy%0d item%0d inst", idx, i), exp_inst,
					got_q[i].inst);
				check_value($sformatf("convoy%0d item%0d rs1_val", idx, i),
					regfile[exp_inst.rs1], got_q[i].rs1_val);
				check_value($sformatf("convoy%0d item%0d rs2_val", idx, i),
					regfile[exp_inst.rs2], got_q[i].rs2_val);
			end
		end
		got_q.delete();
		pending_q.delete();
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////
	initial
	begin
		string       line;
		int          fd;
		int          rc;
		int          convoy;
		logic [31:0] word;
		logic [7:0]  count;
		logic [7:0]  pat;
		reset        = 1'b0;
		clk          = 1'b1;	// Reset asserted from time 0
		instr        = '0;
		instr_strobe = 1'b0;
		exe_stall    = 1'b0;
		exe_done     = 1'b0;
		checks       = 0;
		errors       = 0;
		convoy       = 0;
		lfsr_state   = 32'h24682975;
		for (int r = 0; r < 32; r++)
		begin
			for (int b = 0; b < XLEN; b++)
			begin
				lfsr_state    = lfsr_step(lfsr_state);	// One step per bit
				regfile[r][b] = lfsr_state[0];
			end
		end
		repeat (8) @(posedge reset);
		#DRIVE_DLY;
		clk = 1'b0;
		check_value("reset issue_start", 0, issue_start);
		check_value("reset convoy_busy", 0, convoy_busy);
		check_value("reset issue_clear", 1, issue_clear);
		fd = $fopen("tests/testdata_vector_issue.txt", "r");
		if (fd == 0)
		begin
			errors++;
			$display("Could not open the test data file");
		end
		else
		begin
			while (!$feof(fd))
			begin
				rc = $fgets(line, fd);
				if (rc > 1 && line.getc(0) == "I")
				begin
					rc = $sscanf(line.substr(1, line.len() - 1), "%h", word);
					strobe_word(word);
					if (is_vector(word))
						pending_q.push_back(word);
				end
				else if (rc > 1 && line.getc(0) == "T")
				begin
					rc = $sscanf(line.substr(1, line.len() - 1), "%h %b",
						count, pat);
					run_convoy(count, pat, convoy);
					convoy++;
				end
			end
			$fclose(fd);
		end
		repeat (2) next_cycle();
		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/testdata_vector_issue.txt ====
# I <hex word>     strobe one instruction word for one cycle
# T <issue count> <stall bits>   dispatch a convoy, leftmost stall bit drives the first cycle
I 00000013
I 00208033
T 0 00000000
I 0632E107
I 28754257
I 9E18BFD7
I 0CCA7427
I F3EE80D7
I 00C58593
T 5 01101001
I 1290C0D7
I 22A14157
I 32B1C1D7
I 42C24257
I 00528287
I 06633327
I 72F3C3D7
I 83044457
I 9314C4D7
I A3254557
T 8 10010110
I 00000013
I 00B58587
I 0632E107
I 00208033
T 2 11100110

// ==== build.f ====
rtl/vec_pkg.sv
rtl/vec_decode_stage.sv
rtl/inst_record.sv
rtl/dispatch_stage.sv
rtl/vector_issue_top.sv
tests/tb_vector_issue.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the vector issue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_vector_issue \
	-f build.f -o sim_vector_issue
./obj_dir/sim_vector_issue | tee sim.log

if grep -q "TEST PASSED" sim.log; then
	exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
